// File: st_bus_pkg.sv
/*
 * bus-side definitions for the ST glue
 * cpu address union, bus slot codes, RAM size codes, I/O device windows
 */
package st_bus_pkg;

	// memory view of address bits 23..1
	typedef struct packed {
		logic [7:0]  page;
		logic [14:0] offset;
	} mem_view_t;

	// interrupt acknowledge view, a1..a3 carry the level
	typedef struct packed {
		logic [19:0] iack_prefix;
		logic [2:0]  level;
	} iack_view_t;

	// one cpu address word, decoded both ways
	typedef union packed {
		mem_view_t  mem_view;
		iack_view_t iack_view;
	} cpu_addr_t;

	// four-slot bus timing
	typedef logic [1:0] slot_t;
	localparam slot_t SLOT_VIDEO = 2'd0;
	localparam slot_t SLOT_CPU   = 2'd1;
	localparam slot_t SLOT_IDLE  = 2'd2;
	localparam slot_t SLOT_CPU2  = 2'd3;

	// configured ram size
	typedef logic [2:0] mem_size_t;
	localparam mem_size_t MEM_512K = 3'd0;
	localparam mem_size_t MEM_1M   = 3'd1;
	localparam mem_size_t MEM_2M   = 3'd2;
	localparam mem_size_t MEM_4M   = 3'd3;
	localparam mem_size_t MEM_8M   = 3'd4;
	localparam mem_size_t MEM_14M  = 3'd5;

	localparam logic [7:0]  IO_PAGE     = 8'hff;
	localparam logic [7:0]  CART_PAGE   = 8'hfa;
	localparam logic [19:0] IACK_PREFIX = 20'hfffff;

	// one select bit per peripheral register block
	localparam int IO_DEV_COUNT = 11;
	typedef logic [IO_DEV_COUNT-1:0] io_sel_t;

	localparam int IO_MMU       = 0;
	localparam int IO_VIDEO     = 1;
	localparam int IO_DMA       = 2;
	localparam int IO_PSG       = 3;
	localparam int IO_BLITTER   = 4;
	localparam int IO_ACIA      = 5;
	localparam int IO_MFP       = 6;
	localparam int IO_STE_JOY   = 7;
	localparam int IO_STE_SND   = 8;
	localparam int IO_MSTE_CTRL = 9;
	localparam int IO_VME       = 10;

	// low 16 address bits of each window, in device index order
	localparam logic [15:0] IO_BASE [IO_DEV_COUNT] = '{
		16'h8000, 16'h8200, 16'h8600, 16'h8800, 16'h8a00, 16'hfc00,
		16'hfa00, 16'h9200, 16'h8900, 16'h8e20, 16'h8e00
	};
	// window sizes 2, 128, 16, 256, 256, 256, 64, 64, 64, 2, 16 bytes
	localparam logic [15:0] IO_MASK [IO_DEV_COUNT] = '{
		16'hfffe, 16'hff80, 16'hfff0, 16'hff00, 16'hff00, 16'hff00,
		16'hffc0, 16'hffc0, 16'hffc0, 16'hfffe, 16'hfff0
	};

endpackage

// File: st_irq_pkg.sv
/*
 * interrupt-side definitions for the ST glue
 * IPL codes, acknowledge levels, blank vectors, bus-error timeout
 */
package st_irq_pkg;

	// ipl lines are active low, ipl0 stays high on the ST
	typedef logic [2:0] ipl_t;

	localparam ipl_t IPL_MFP  = 3'b001;
	localparam ipl_t IPL_VBI  = 3'b011;
	localparam ipl_t IPL_HBI  = 3'b101;
	localparam ipl_t IPL_NONE = 3'b111;

	// level seen on a1..a3 during an acknowledge cycle
	localparam logic [2:0] LEVEL_MFP = 3'd6;
	localparam logic [2:0] LEVEL_VBI = 3'd4;
	localparam logic [2:0] LEVEL_HBI = 3'd2;

	// vectors for the two blank interrupts
	// mfp supplies its own vector
	localparam logic [7:0] VEC_VBI = 8'h1c;
	localparam logic [7:0] VEC_HBI = 8'h1a;

	// unanswered cpu slots before bus error
	typedef logic [2:0] berr_cnt_t;
	localparam berr_cnt_t BERR_LIMIT = 3'd7;

endpackage

// File: cpu_addr_decode.sv
/*
 * cpu side of the glue: bus slot counter, address strobe,
 * memory region and I/O window decode, acknowledge cycles, RAM strobes
 */
`timescale 1ns/1ps

module cpu_addr_decode (
	input  logic                  clk_8,
	input  logic                  pll_locked,
	input  st_bus_pkg::cpu_addr_t cpu_addr,
	input  logic                  cpu_as_n,
	input  logic                  cpu_rw,
	input  logic                  cpu_uds_n,
	input  logic                  cpu_lds_n,
	input  logic                  bus_req,
	input  st_bus_pkg::mem_size_t mem_size,
	input  logic                  ste,
	input  logic                  mste,
	input  logic                  blitter_fitted,
	input  logic                  fast_cpu_en,
	output logic                  cpu_cycle,
	output st_bus_pkg::io_sel_t   io_sel,
	output logic                  mem_ack,
	output logic                  io_ack,
	output logic                  iack_cycle,
	output logic [2:0]            iack_level,
	output logic                  vbi_ack,
	output logic                  hbi_ack,
	output logic                  mfp_iack,
	output logic                  ram_oe,
	output logic                  ram_wr,
	output logic                  ram_uds,
	output logic                  ram_lds
);
	import st_bus_pkg::*;
	import st_irq_pkg::*;

	slot_t       slot;
	slot_t       slot_next;
	logic        addr_strobe;
	logic [7:0]  page;
	logic [7:0]  ram_top;
	logic        low_rom;
	logic        ram_any;
	logic        ram_cfg;
	logic        rom;
	logic        cart;
	logic        mem_access;
	logic        io_access;
	logic [15:0] io_offset;
	io_sel_t     win_hit;
	io_sel_t     dev_en;

	// video, cpu, idle, optional second cpu slot
	always_comb begin
		case (slot)
			SLOT_VIDEO: slot_next = SLOT_CPU;
			SLOT_CPU:   slot_next = SLOT_IDLE;
			SLOT_IDLE:  slot_next = SLOT_CPU2;
			default:    slot_next = SLOT_VIDEO;
		endcase
	end

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			slot <= SLOT_VIDEO;
		end else begin
			slot <= slot_next;
		end
	end

	// second cpu slot only on a mega ste at 16 MHz
	assign cpu_cycle = (slot == SLOT_CPU) ||
		(mste && fast_cpu_en && (slot == SLOT_CPU2));
	// another master holds the cpu off the bus
	assign addr_strobe = cpu_cycle && !cpu_as_n && !bus_req;

	// memory view
	assign page    = cpu_addr.mem_view.page;
	// rom mirrored at 0..7 for the reset vectors
	assign low_rom = (cpu_addr.mem_view.page == 8'h00) &&
		(cpu_addr.mem_view.offset[14:2] == 13'd0);

	// top of ram for the configured size, 4M window always present
	always_comb begin
		case (mem_size)
			MEM_512K: ram_top = 8'h40;
			MEM_1M:   ram_top = 8'h40;
			MEM_2M:   ram_top = 8'h40;
			MEM_4M:   ram_top = 8'h40;
			MEM_8M:   ram_top = 8'h80;
			MEM_14M:  ram_top = 8'he0;
			default:  ram_top = 8'h40;
		endcase
	end

	assign ram_cfg = !low_rom && (page < ram_top);
	// full 14M map, used for the cpu access check
	assign ram_any = !low_rom && (page < 8'he0);

	// tos at e00000..e3ffff and fc0000..feffff
	assign rom = (page[7:2] == 6'b111000) || (page[7:1] == 7'b1111110) ||
		(page == 8'hfe) || low_rom;
	assign cart = ({page[7:1], 1'b0} == CART_PAGE);

	// rom and cartridge are read only
	assign mem_access = ram_any || (cpu_rw && (rom || cart));
	assign io_access  = (page == IO_PAGE);
	assign mem_ack    = addr_strobe && mem_access;

	// register windows inside the io page
	assign io_offset = {cpu_addr.mem_view.offset, 1'b0};

	always_comb begin
		for (int i = 0; i < IO_DEV_COUNT; i++) begin
			win_hit[i] = ((io_offset & IO_MASK[i]) == IO_BASE[i]);
		end
	end

	// devices that depend on the machine type
	always_comb begin
		dev_en               = '0;
		dev_en[IO_MMU]       = 1'b1;
		dev_en[IO_VIDEO]     = 1'b1;
		dev_en[IO_DMA]       = 1'b1;
		dev_en[IO_PSG]       = 1'b1;
		// ste always has a blitter
		dev_en[IO_BLITTER]   = blitter_fitted || ste;
		dev_en[IO_ACIA]      = 1'b1;
		dev_en[IO_MFP]       = 1'b1;
		dev_en[IO_STE_JOY]   = ste;
		dev_en[IO_STE_SND]   = ste;
		dev_en[IO_MSTE_CTRL] = mste;
		dev_en[IO_VME]       = mste;
	end

	assign io_sel = win_hit & dev_en & {IO_DEV_COUNT{io_access && addr_strobe}};

	// acknowledge view of the same address word
	assign iack_cycle = addr_strobe && (cpu_addr.iack_view.iack_prefix == IACK_PREFIX);
	assign iack_level = cpu_addr.iack_view.level;
	assign mfp_iack   = iack_cycle && (iack_level == LEVEL_MFP);
	assign vbi_ack    = iack_cycle && (iack_level == LEVEL_VBI);
	assign hbi_ack    = iack_cycle && (iack_level == LEVEL_HBI);
	assign io_ack     = (|io_sel) || mfp_iack || vbi_ack || hbi_ack;

	// ram strobes only for the cpu, never while bus_req
	assign ram_oe  = addr_strobe && cpu_rw && mem_access;
	assign ram_wr  = addr_strobe && !cpu_rw && ram_cfg;
	assign ram_uds = cpu_cycle && !bus_req && !cpu_uds_n;
	assign ram_lds = cpu_cycle && !bus_req && !cpu_lds_n;

endmodule

// File: irq_ctrl.sv
/*
 * blank interrupt sources
 * sync edge detectors and pending latches for vbi and hbi
 */
`timescale 1ns/1ps

module irq_ctrl (
	input  logic clk_8,
	input  logic pll_locked,
	input  logic st_vs,
	input  logic st_hs,
	input  logic vbi_ack,
	input  logic hbi_ack,
	output logic vbi,
	output logic hbi
);

	// bit 0 is the vertical path, bit 1 the horizontal one
	logic [1:0] sync_in;
	logic [1:0] sync_ack;
	logic [1:0] sync_d;
	logic [1:0] sync_d2;
	logic [1:0] sync_pulse;
	logic [1:0] pending;

	assign sync_in  = {st_hs, st_vs};
	assign sync_ack = {hbi_ack, vbi_ack};

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			sync_d     <= 2'b00;
			sync_d2    <= 2'b00;
			sync_pulse <= 2'b00;
			pending    <= 2'b00;
		end else begin
			// sample sync levels
			sync_d     <= sync_in;
			// delayed copy for edge detect
			sync_d2    <= sync_d;
			// single cycle pulse on rising edge
			sync_pulse <= sync_d & ~sync_d2;
			// set on pulse, ack wins when both arrive together
			pending    <= (pending | sync_pulse) & ~sync_ack;
		end
	end

	assign vbi = pending[0];
	assign hbi = pending[1];

endmodule

// File: bus_response.sv
/*
 * bus response to the cpu: DTACK, bus-error timeout,
 * registered IPL priority encoder, blank interrupt vectors
 */
`timescale 1ns/1ps

module bus_response (
	input  logic              clk_8,
	input  logic              pll_locked,
	input  logic              cpu_cycle,
	input  logic              cpu_as_n,
	input  logic              bus_req,
	input  logic              mem_ack,
	input  logic              io_ack,
	input  logic              iack_cycle,
	input  logic [2:0]        iack_level,
	input  logic              clr_berr,
	input  logic              vbi,
	input  logic              hbi,
	input  logic              mfp_irq,
	output logic              dtack_n,
	output logic              berr,
	output st_irq_pkg::ipl_t  ipl,
	output logic [7:0]        auto_vector
);
	import st_irq_pkg::*;

	berr_cnt_t berr_cnt;

	// any decoded target answers, unless another master owns the bus
	assign dtack_n = !((mem_ack || io_ack) && !bus_req);

	// count cpu slots without dtack
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			berr_cnt <= '0;
		end else if (clr_berr) begin
			berr_cnt <= '0;
		end else if (cpu_cycle && (berr_cnt != BERR_LIMIT)) begin
			// restart when answered, bus taken or no cycle pending
			if (!dtack_n || bus_req || cpu_as_n) begin
				berr_cnt <= '0;
			end else begin
				berr_cnt <= berr_cnt + 3'd1;
			end
		end
	end

	// counter parks at the limit until the cpu clears it
	assign berr = (berr_cnt == BERR_LIMIT);

	// mfp above vbi above hbi
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			ipl <= IPL_NONE;
		end else if (mfp_irq) begin
			ipl <= IPL_MFP;
		end else if (vbi) begin
			ipl <= IPL_VBI;
		end else if (hbi) begin
			ipl <= IPL_HBI;
		end else begin
			ipl <= IPL_NONE;
		end
	end

	// vectors for the autovector levels
	// the cpu runs in vectored mode, so glue supplies them
	always_comb begin
		auto_vector = 8'h00;
		if (iack_cycle && (iack_level == LEVEL_VBI)) begin
			auto_vector = VEC_VBI;
		end else if (iack_cycle && (iack_level == LEVEL_HBI)) begin
			auto_vector = VEC_HBI;
		end
	end

endmodule

// File: st_glue_top.sv
/*
 * ST bus glue top level
 * address decode, blank interrupts and bus response
 */
`timescale 1ns/1ps

module st_glue_top (
	input  logic                  clk_8,
	input  logic                  pll_locked,
	input  st_bus_pkg::cpu_addr_t cpu_addr,
	input  logic                  cpu_as_n,
	input  logic                  cpu_rw,
	input  logic                  cpu_uds_n,
	input  logic                  cpu_lds_n,
	input  logic                  bus_req,
	input  logic                  clr_berr,
	input  st_bus_pkg::mem_size_t mem_size,
	input  logic                  ste,
	input  logic                  mste,
	input  logic                  blitter_fitted,
	input  logic                  fast_cpu_en,
	input  logic                  st_vs,
	input  logic                  st_hs,
	input  logic                  mfp_irq,
	output st_bus_pkg::io_sel_t   io_sel,
	output logic                  mfp_iack,
	output logic                  ram_oe,
	output logic                  ram_wr,
	output logic                  ram_uds,
	output logic                  ram_lds,
	output logic                  dtack_n,
	output logic                  berr,
	output st_irq_pkg::ipl_t      ipl,
	output logic [7:0]            auto_vector
);

	// decode to response
	logic       cpu_cycle;
	logic       mem_ack;
	logic       io_ack;
	logic       iack_cycle;
	logic [2:0] iack_level;
	// acknowledge to interrupt latches
	logic       vbi_ack;
	logic       hbi_ack;
	// pending blank interrupts
	logic       vbi;
	logic       hbi;

	cpu_addr_decode u_decode (
		.clk_8          (clk_8),
		.pll_locked     (pll_locked),
		.cpu_addr       (cpu_addr),
		.cpu_as_n       (cpu_as_n),
		.cpu_rw         (cpu_rw),
		.cpu_uds_n      (cpu_uds_n),
		.cpu_lds_n      (cpu_lds_n),
		.bus_req        (bus_req),
		.mem_size       (mem_size),
		.ste            (ste),
		.mste           (mste),
		.blitter_fitted (blitter_fitted),
		.fast_cpu_en    (fast_cpu_en),
		.cpu_cycle      (cpu_cycle),
		.io_sel         (io_sel),
		.mem_ack        (mem_ack),
		.io_ack         (io_ack),
		.iack_cycle     (iack_cycle),
		.iack_level     (iack_level),
		.vbi_ack        (vbi_ack),
		.hbi_ack        (hbi_ack),
		.mfp_iack       (mfp_iack),
		.ram_oe         (ram_oe),
		.ram_wr         (ram_wr),
		.ram_uds        (ram_uds),
		.ram_lds        (ram_lds)
	);

	irq_ctrl u_irq (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.st_vs      (st_vs),
		.st_hs      (st_hs),
		.vbi_ack    (vbi_ack),
		.hbi_ack    (hbi_ack),
		.vbi        (vbi),
		.hbi        (hbi)
	);

	bus_response u_resp (
		.clk_8       (clk_8),
		.pll_locked  (pll_locked),
		.cpu_cycle   (cpu_cycle),
		.cpu_as_n    (cpu_as_n),
		.bus_req     (bus_req),
		.mem_ack     (mem_ack),
		.io_ack      (io_ack),
		.iack_cycle  (iack_cycle),
		.iack_level  (iack_level),
		.clr_berr    (clr_berr),
		.vbi         (vbi),
		.hbi         (hbi),
		.mfp_irq     (mfp_irq),
		.dtack_n     (dtack_n),
		.berr        (berr),
		.ipl         (ipl),
		.auto_vector (auto_vector)
	);

endmodule

// File: tb_st_glue_assertions.sv
/*
 * concurrent checks on bus_response
 * bus error counter, IPL after reset, acknowledges under bus_req
 */
`timescale 1ns/1ps

module bus_response_assertions (
	input logic                  clk_8,
	input logic                  pll_locked,
	input logic                  bus_req,
	input logic                  clr_berr,
	input logic                  mem_ack,
	input logic                  io_ack,
	input logic                  berr,
	input st_irq_pkg::berr_cnt_t berr_cnt,
	input st_irq_pkg::ipl_t      ipl
);
	import st_irq_pkg::*;

	// failed checks so far
	int unsigned fail_count = 0;

	// berr only rises from the last count below the limit
	berr_after_count: assert property (@(posedge clk_8) disable iff (!pll_locked)
		$rose(berr) |-> ($past(berr_cnt) == BERR_LIMIT - 3'd1))
		else begin
			fail_count++;
			$error("berr rose without the timeout counter one below its limit");
		end

	// held until the cpu clears it
	berr_held: assert property (@(posedge clk_8) disable iff (!pll_locked)
		(berr && !clr_berr) |=> berr)
		else begin
			fail_count++;
			$error("berr dropped without clr_berr");
		end

	// first edge out of reset
	ipl_idle_after_reset: assert property (@(posedge clk_8)
		$rose(pll_locked) |-> (ipl == IPL_NONE))
		else begin
			fail_count++;
			$error("ipl not idle after reset");
		end

	// no target answers while another master owns the bus
	no_ack_on_bus_req: assert property (@(posedge clk_8) disable iff (!pll_locked)
		bus_req |-> !(mem_ack || io_ack))
		else begin
			fail_count++;
			$error("acknowledge present while bus_req is set");
		end

endmodule

bind bus_response bus_response_assertions u_checks (
	.clk_8      (clk_8),
	.pll_locked (pll_locked),
	.bus_req    (bus_req),
	.clr_berr   (clr_berr),
	.mem_ack    (mem_ack),
	.io_ack     (io_ack),
	.berr       (berr),
	.berr_cnt   (berr_cnt),
	.ipl        (ipl)
);

// File: tb_st_glue.sv
/*
 * testbench for the ST bus glue
 * clock, reset, LFSR stimulus, reference model, compare tasks
 */
`timescale 1ns/1ps

module tb_st_glue;
	import st_bus_pkg::*;
	import st_irq_pkg::*;

	logic       clk_8;
	logic       pll_locked;
	cpu_addr_t  cpu_addr;
	logic       cpu_as_n, cpu_rw, cpu_uds_n, cpu_lds_n, bus_req, clr_berr;
	mem_size_t  mem_size;
	logic       ste, mste, blitter_fitted, fast_cpu_en, st_vs, st_hs, mfp_irq;
	io_sel_t    io_sel;
	logic       mfp_iack, ram_oe, ram_wr, ram_uds, ram_lds, dtack_n, berr;
	ipl_t       ipl;
	logic [7:0] auto_vector;

	logic [31:0] lfsr = 32'h60fa3b40;
	// model state
	// bit 0 of the sync vectors is vertical
	slot_t      m_slot;
	berr_cnt_t  m_cnt;
	logic [1:0] m_d, m_d2, m_pulse, m_pend;
	ipl_t       m_ipl;
	// expected values for the current cycle
	io_sel_t    e_io_sel;
	logic       e_cpu, e_mfp_iack, e_oe, e_wr, e_uds, e_lds, e_dtack_n, e_vack, e_hack;
	logic [7:0] e_vector;
	logic       seen_berr, seen_cpu;

	// byte offset and size of each register window in the ff page
	int win_base [11] = '{'h8000, 'h8200, 'h8600, 'h8800, 'h8a00, 'hfc00,
		'hfa00, 'h9200, 'h8900, 'h8e20, 'h8e00};
	int win_size [11] = '{2, 128, 16, 256, 256, 256, 64, 64, 64, 2, 16};
	// upper offset bytes that land near a window
	logic [7:0] io_hi [16] = '{8'h80, 8'h82, 8'h86, 8'h88, 8'h89, 8'h8a, 8'h8e, 8'h92,
		8'hfa, 8'hfc, 8'h80, 8'h84, 8'h8e, 8'h90, 8'hfa, 8'hfc};

	st_glue_top UUT (.*);

	initial begin
		clk_8 = 1'b0;
		forever #50 clk_8 = ~clk_8;
	end

	// galois lfsr stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        b;
		v = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr[0];
			lfsr = lfsr >> 1;
			if (b) lfsr = lfsr ^ 32'h80200003;
			v = {v[30:0], b};
		end
		return v;
	endfunction

	// failures flagged by the bound checker
	function automatic bit assertions_failed();
		return UUT.u_resp.u_checks.fail_count != 0;
	endfunction

	task automatic report_mismatch(input string name, input string got, input string exp);
		$display("mismatch at %0t: %s is %s, expected %s", $time, name, got, exp);
		$display("TEST FAIL");
		$fatal(1, "%s mismatch", name);
	endtask

	task automatic fail_run(input string why);
		$display("%s at %0t", why, $time);
		$display("TEST FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
	endtask

	task automatic check_io_sel(input string name, input io_sel_t got, input io_sel_t exp);
		if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic check_ipl(input string name, input ipl_t got, input ipl_t exp);
		if (got !== exp) report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
	endtask

	task automatic check_vector(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic reset_model();
		m_slot  = SLOT_VIDEO;
		m_cnt   = '0;
		m_d     = 2'b00;
		m_d2    = 2'b00;
		m_pulse = 2'b00;
		m_pend  = 2'b00;
		m_ipl   = IPL_NONE;
	endtask

	// decode rules for the current slot and inputs
	task automatic predict();
		logic [7:0] page;
		logic [7:0] ram_top;
		logic [2:0] lvl;
		int         off;
		logic       strobe, low_rom, rom, cart, mem_acc, iack;
		page    = cpu_addr[22:15];
		off     = int'({cpu_addr[14:0], 1'b0});
		lvl     = cpu_addr[2:0];
		ram_top = (mem_size == MEM_14M) ? 8'he0 : ((mem_size == MEM_8M) ? 8'h80 : 8'h40);
		e_cpu   = (m_slot == SLOT_CPU) || (mste && fast_cpu_en && (m_slot == SLOT_CPU2));
		strobe  = e_cpu && !cpu_as_n && !bus_req;
		low_rom = (page == 8'h00) && (off < 8);
		rom     = (page >= 8'he0 && page <= 8'he3) || (page >= 8'hfc && page <= 8'hfe);
		rom     = rom || low_rom;
		cart    = (page == 8'hfa) || (page == 8'hfb);
		// cpu sees the whole 14M map
		// writes only hit configured ram
		mem_acc = (!low_rom && page < 8'he0) || (cpu_rw && (rom || cart));
		iack    = strobe && (cpu_addr[22:3] == 20'hfffff);
		for (int i = 0; i < IO_DEV_COUNT; i++) begin
			e_io_sel[i] = strobe && (page == 8'hff) && (off >= win_base[i]) &&
				(off < win_base[i] + win_size[i]);
		end
		e_io_sel[IO_BLITTER]   &= blitter_fitted || ste;
		e_io_sel[IO_STE_JOY]   &= ste;
		e_io_sel[IO_STE_SND]   &= ste;
		e_io_sel[IO_MSTE_CTRL] &= mste;
		e_io_sel[IO_VME]       &= mste;
		e_mfp_iack = iack && (lvl == 3'd6);
		e_vack     = iack && (lvl == 3'd4);
		e_hack     = iack && (lvl == 3'd2);
		e_dtack_n  = !(((strobe && mem_acc) || (|e_io_sel) || e_mfp_iack || e_vack || e_hack)
			&& !bus_req);
		e_oe       = strobe && cpu_rw && mem_acc;
		e_wr       = strobe && !cpu_rw && !low_rom && (page < ram_top);
		e_uds      = e_cpu && !bus_req && !cpu_uds_n;
		e_lds      = e_cpu && !bus_req && !cpu_lds_n;
		e_vector   = e_vack ? 8'h1c : (e_hack ? 8'h1a : 8'h00);
	endtask

	// state after the coming edge
	// each line reads values not yet updated
	task automatic step_model();
		if (clr_berr)
			m_cnt = '0;
		else if (e_cpu && (m_cnt != BERR_LIMIT))
			m_cnt = (!e_dtack_n || bus_req || cpu_as_n) ? 3'd0 : m_cnt + 3'd1;
		m_ipl   = mfp_irq ? IPL_MFP : (m_pend[0] ? IPL_VBI : (m_pend[1] ? IPL_HBI : IPL_NONE));
		m_pend  = (m_pend | m_pulse) & ~{e_hack, e_vack};
		m_pulse = m_d & ~m_d2;
		m_d2    = m_d;
		m_d     = {st_hs, st_vs};
		m_slot  = m_slot + 2'd1;
	endtask

	// check at the falling edge and return on the next rising edge
	task automatic tick();
		@(negedge clk_8);
		predict();
		check_io_sel("io_sel", io_sel, e_io_sel);
		check_bit("mfp_iack", mfp_iack, e_mfp_iack);
		check_bit("ram_oe", ram_oe, e_oe);
		check_bit("ram_wr", ram_wr, e_wr);
		check_bit("ram_uds", ram_uds, e_uds);
		check_bit("ram_lds", ram_lds, e_lds);
		check_bit("dtack_n", dtack_n, e_dtack_n);
		check_bit("berr", berr, m_cnt == BERR_LIMIT);
		check_ipl("ipl", ipl, m_ipl);
		check_vector("auto_vector", auto_vector, e_vector);
		if (assertions_failed()) fail_run("an assertion on bus_response failed");
		seen_berr = berr;
		seen_cpu  = e_cpu;
		step_model();
		@(posedge clk_8);
	endtask

	task automatic set_config(input int phase);
		mem_size       <= 3'(phase % 6);
		ste            <= 1'(rand_bits(1));
		mste           <= 1'(rand_bits(1));
		blitter_fitted <= 1'(rand_bits(1));
		fast_cpu_en    <= 1'(rand_bits(1));
	endtask

	task automatic drive_random();
		logic [2:0] kind;
		logic [7:0] hi;
		logic [6:0] lo;
		kind = 3'(rand_bits(3));
		hi   = io_hi[4'(rand_bits(4))];
		// small low offsets reach the two byte windows
		lo   = rand_bits(1) ? 7'(rand_bits(7)) : 7'(rand_bits(3));
		case (kind)
			3'd0, 3'd1, 3'd2, 3'd3: cpu_addr <= {8'hff, hi, lo};
			3'd4:    cpu_addr <= {20'hfffff, 3'(rand_bits(3))};
			// e4..f3 holds nothing
			3'd5:    cpu_addr <= {8'he4 + 8'(rand_bits(4)), 15'(rand_bits(15))};
			default: cpu_addr <= 23'(rand_bits(23));
		endcase
		cpu_as_n  <= (rand_bits(2) == 32'd3);
		cpu_rw    <= 1'(rand_bits(1));
		cpu_uds_n <= 1'(rand_bits(1));
		cpu_lds_n <= 1'(rand_bits(1));
		bus_req   <= (rand_bits(3) == 32'd7);
		clr_berr  <= (rand_bits(5) == 32'd0);
		if (rand_bits(3) == 32'd0) st_vs <= !st_vs;
		if (rand_bits(2) == 32'd0) st_hs <= !st_hs;
		if (rand_bits(4) == 32'd0) mfp_irq <= !mfp_irq;
	endtask

	// unanswered cycle on unmapped space until bus error
	task automatic berr_test();
		int n;
		int slots;
		cpu_addr <= {8'he8, 15'h0100};
		cpu_as_n <= 1'b0;
		cpu_rw   <= 1'b1;
		bus_req  <= 1'b0;
		clr_berr <= 1'b1;
		tick();
		clr_berr <= 1'b0;
		n     = 0;
		slots = 0;
		tick();
		while (!seen_berr) begin
			if (seen_cpu) slots++;
			n++;
			if (n > 64) fail_run("bus error never rose on an unanswered cycle");
			tick();
		end
		if (slots != 7) fail_run("bus error rose after the wrong number of CPU slots");
		repeat (8) tick();
		clr_berr <= 1'b1;
		cpu_as_n <= 1'b1;
		tick();
		clr_berr <= 1'b0;
		n = 0;
		tick();
		while (seen_berr) begin
			n++;
			if (n > 16) fail_run("bus error stayed high after clr_berr");
			tick();
		end
	endtask

	initial begin
		pll_locked <= 1'b0;
		cpu_addr   <= '0;
		cpu_as_n   <= 1'b1;
		cpu_rw     <= 1'b1;
		cpu_uds_n  <= 1'b1;
		cpu_lds_n  <= 1'b1;
		bus_req    <= 1'b0;
		clr_berr   <= 1'b0;
		st_vs      <= 1'b0;
		st_hs      <= 1'b0;
		mfp_irq    <= 1'b0;
		set_config(0);
		repeat (5) @(posedge clk_8);
		pll_locked <= 1'b1;
		reset_model();
		for (int phase = 0; phase < 12; phase++) begin
			set_config(phase);
			repeat (150) begin
				tick();
				drive_random();
			end
			berr_test();
		end
		@(negedge clk_8);
		if (assertions_failed()) begin
			fail_run("an assertion on bus_response failed");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

// File: project.f
st_bus_pkg.sv
st_irq_pkg.sv
cpu_addr_decode.sv
irq_ctrl.sv
bus_response.sv
st_glue_top.sv
tb_st_glue_assertions.sv
tb_st_glue.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the ST glue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_st_glue \
	-f project.f

# exit status of the simulation is the result
./obj_dir/Vtb_st_glue
